// File: compile.f
mmu_cfg_pkg.sv
mmu_types_pkg.sv
tlb_cam.sv
tlb.sv
tlb_miss_arbiter.sv
mmu_top.sv
tb_mmu_checker.sv
tb_mmu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mmu
RTL_TOP   ?= mmu_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) \
		mmu_cfg_pkg.sv mmu_types_pkg.sv tlb_cam.sv tlb.sv tlb_miss_arbiter.sv mmu_top.sv

clean:
	rm -rf $(OBJ_DIR)

// File: tb_mmu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mmu;
  import mmu_cfg_pkg::*;
  import mmu_types_pkg::*;

  localparam int clk_period     = 8;
  localparam int pt_cycles      = 40;
  localparam int run_cycles     = 1200;
  localparam int n_ops          = pt_cycles + run_cycles + 60;
  localparam int worst_fill_lat = 8; // walker wait plus request and write cycles
  localparam int timeout_ns     = n_ops * worst_fill_lat * clk_period;

  logic                  clk, reset, translation_en, flush, fill_v;
  tlb_req_s              ifetch_req, dmem_req;
  fill_pte_s             fill_pte;
  logic                  i_v, i_miss_v, d_v, d_miss_v, fill_req_v;
  itlb_entry_s           i_entry;
  dtlb_entry_s           d_entry;
  logic [vtag_width-1:0] fill_req_vtag, last_i, last_d;
  logic [31:0]           lfsr_q;
  int                    wait_cnt, err_cnt, hit_cnt, fill_cnt, other_err;

  mmu_top mmu_top_i (
    .clk_i            (clk),
    .reset_i          (reset),
    .translation_en_i (translation_en),
    .flush_i          (flush),
    .ifetch_req_i     (ifetch_req),
    .dmem_req_i       (dmem_req),
    .fill_v_i         (fill_v),
    .fill_pte_i       (fill_pte),
    .i_v_o            (i_v),
    .i_miss_v_o       (i_miss_v),
    .i_entry_o        (i_entry),
    .d_v_o            (d_v),
    .d_miss_v_o       (d_miss_v),
    .d_entry_o        (d_entry),
    .fill_req_v_o     (fill_req_v),
    .fill_req_vtag_o  (fill_req_vtag)
  );

  tb_mmu_checker chk_u (
    .clk_i            (clk),
    .reset_i          (reset),
    .translation_en_i (translation_en),
    .flush_i          (flush),
    .ifetch_req_i     (ifetch_req),
    .dmem_req_i       (dmem_req),
    .fill_v_i         (fill_v),
    .fill_pte_i       (fill_pte),
    .i_v_i            (i_v),
    .i_miss_v_i       (i_miss_v),
    .i_entry_i        (i_entry),
    .d_v_i            (d_v),
    .d_miss_v_i       (d_miss_v),
    .d_entry_i        (d_entry),
    .fill_req_v_i     (fill_req_v),
    .fill_req_vtag_i  (fill_req_vtag),
    .err_cnt_o        (err_cnt),
    .hit_cnt_o        (hit_cnt),
    .fill_cnt_o       (fill_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // walker mapping: fixed offset, permissions from low vtag bits
  function automatic fill_pte_s walk_pte(input logic [vtag_width-1:0] vtag);
    fill_pte_s p;
    p.ptag = ptag_width'(vtag) + 24'h40_0000;
    p.r    = vtag[0];
    p.w    = vtag[1];
    p.x    = vtag[2];
    return p;
  endfunction

  // small pool so hits, repeats and evictions all happen
  function automatic tlb_req_s pick_req(input logic [vtag_width-1:0] last);
    tlb_req_s r;
    r = '0;
    if (rand_bits(2) != 0) begin
      r.v = 1'b1;
      if (rand_bits(2) == 0)
        r.vtag = last;
      else
        r.vtag = 20'h0_1000 + vtag_width'(rand_bits(4) % 12);
    end
    return r;
  endfunction

  task automatic drive_cycle(input logic lookups_ok);
    logic block;
    @(negedge clk);
    block = fill_v; // fill write cycle, lookups would be dropped
    flush = 1'b0;
    if (fill_v) begin
      fill_v = 1'b0;
    end else if (fill_req_v) begin
      if (wait_cnt < 0)
        wait_cnt = int'(rand_bits(2));
      if (wait_cnt == 0) begin
        fill_v   = 1'b1;
        fill_pte = walk_pte(fill_req_vtag);
        wait_cnt = -1;
      end else begin
        wait_cnt--;
      end
    end else begin
      wait_cnt = -1;
    end
    ifetch_req = '0;
    dmem_req   = '0;
    if (lookups_ok && !block) begin
      ifetch_req = pick_req(last_i);
      dmem_req   = pick_req(last_d);
      if (ifetch_req.v)
        last_i = ifetch_req.vtag;
      if (dmem_req.v)
        last_d = dmem_req.vtag;
    end
  endtask

  initial begin
    #(timeout_ns);
    $display("watchdog expired before the run finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    reset          = 1'b1;
    translation_en = 1'b0;
    flush          = 1'b0;
    fill_v         = 1'b0;
    fill_pte       = '0;
    ifetch_req     = '0;
    dmem_req       = '0;
    lfsr_q         = 32'd79567;
    wait_cnt       = -1;
    last_i         = 20'h0_1000;
    last_d         = 20'h0_1000;
    other_err      = 0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    repeat (pt_cycles) drive_cycle(1'b1);
    drive_cycle(1'b0);
    translation_en = 1'b1;

    // both sides miss together, instruction refill goes first
    drive_cycle(1'b0);
    flush = 1'b1;
    drive_cycle(1'b0);
    drive_cycle(1'b0);
    ifetch_req = '{v: 1'b1, w: 1'b0, vtag: 20'h0_2000};
    dmem_req   = '{v: 1'b1, w: 1'b0, vtag: 20'h0_2001};
    repeat (25) drive_cycle(1'b0);

    for (int n = 0; n < run_cycles; n++) begin
      drive_cycle(1'b1);
      if (rand_bits(7) == 0)
        flush = 1'b1;
    end
    repeat (30) drive_cycle(1'b0);

    if (hit_cnt == 0 || fill_cnt == 0) begin
      $display("no translated hits or no refills were seen during the run");
      other_err++;
    end
    $display("checker errors: %0d, other failures: %0d, hits: %0d, refills: %0d",
             err_cnt, other_err, hit_cnt, fill_cnt);
    if (err_cnt == 0 && other_err == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_mmu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mmu_checker (
  input  wire                                clk_i,
  input  wire                                reset_i,
  input  wire                                translation_en_i,
  input  wire                                flush_i,
  input  mmu_types_pkg::tlb_req_s            ifetch_req_i,
  input  mmu_types_pkg::tlb_req_s            dmem_req_i,
  input  wire                                fill_v_i,
  input  mmu_types_pkg::fill_pte_s           fill_pte_i,
  input  wire                                i_v_i,
  input  wire                                i_miss_v_i,
  input  mmu_types_pkg::itlb_entry_s         i_entry_i,
  input  wire                                d_v_i,
  input  wire                                d_miss_v_i,
  input  mmu_types_pkg::dtlb_entry_s         d_entry_i,
  input  wire                                fill_req_v_i,
  input  wire  [mmu_cfg_pkg::vtag_width-1:0] fill_req_vtag_i,
  output int                                 err_cnt_o,
  output int                                 hit_cnt_o,
  output int                                 fill_cnt_o
);
  import mmu_cfg_pkg::*;
  import mmu_types_pkg::*;

  localparam int max_els = (itlb_els > dtlb_els) ? itlb_els : dtlb_els;

  // reference state, index 0 is the instruction side
  logic                  vld [2][max_els];
  logic [vtag_width-1:0] tg [2][max_els];
  fill_pte_s             dat [2][max_els];
  int                    vic [2];
  logic                  rv [2], rhit [2], last_rd [2], pend [2];
  logic [vtag_width-1:0] rtag [2], ptag_q [2];
  fill_pte_s             rdat [2];
  logic                  busy, serve_d, wr_v, wr_d;
  logic [vtag_width-1:0] wr_tag;
  fill_pte_s             wr_pte;

  initial begin
    err_cnt_o  = 0;
    hit_cnt_o  = 0;
    fill_cnt_o = 0;
  end

  function automatic int side_els(input int s);
    return (s == 0) ? itlb_els : dtlb_els;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt_o++;
      $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // fully associative lookup of the reference array
  function automatic logic ref_lookup(input int s, input logic [vtag_width-1:0] t,
                                      output fill_pte_s p);
    logic hit;
    hit = 1'b0;
    p   = '0;
    for (int i = 0; i < side_els(s); i++) begin
      if (vld[s][i] && tg[s][i] == t) begin
        hit = 1'b1;
        p   = dat[s][i];
      end
    end
    return hit;
  endfunction

  // update in place if present, else round robin victim
  task automatic ref_write(input int s, input logic [vtag_width-1:0] t, input fill_pte_s p);
    int   idx;
    logic found;
    idx   = vic[s];
    found = 1'b0;
    for (int i = 0; i < side_els(s); i++) begin
      if (vld[s][i] && tg[s][i] == t) begin
        idx   = i;
        found = 1'b1;
      end
    end
    vld[s][idx] = 1'b1;
    tg[s][idx]  = t;
    dat[s][idx] = p;
    if (!found)
      vic[s] = (vic[s] + 1) % side_els(s);
  endtask

  always @(posedge clk_i) begin
    logic                  ev [2], em [2];
    logic                  exp_req, sel_d, fill_hit, rd, byp;
    logic [vtag_width-1:0] exp_tag;
    tlb_req_s              req;
    if (reset_i) begin
      for (int s = 0; s < 2; s++) begin
        for (int i = 0; i < max_els; i++)
          vld[s][i] = 1'b0;
        vic[s]     = 0;
        rv[s]      = 1'b0;
        last_rd[s] = 1'b0;
        pend[s]    = 1'b0;
      end
      busy    = 1'b0;
      serve_d = 1'b0;
      wr_v    = 1'b0;
    end else begin
      for (int s = 0; s < 2; s++) begin
        ev[s] = translation_en_i ? (rv[s] & rhit[s]) : rv[s];
        em[s] = rv[s] & ~ev[s];
      end
      check("i_v_o", 32'(i_v_i), 32'(ev[0]));
      check("i_miss_v_o", 32'(i_miss_v_i), 32'(em[0]));
      check("d_v_o", 32'(d_v_i), 32'(ev[1]));
      check("d_miss_v_o", 32'(d_miss_v_i), 32'(em[1]));
      if (ev[0]) // passthrough has no permissions
        check("i_entry_o", 32'(i_entry_i), translation_en_i ?
              32'({rdat[0].ptag, rdat[0].x}) : 32'({ptag_width'(rtag[0]), 1'b0}));
      if (ev[1])
        check("d_entry_o", 32'(d_entry_i), translation_en_i ?
              32'({rdat[1].ptag, rdat[1].r, rdat[1].w}) : 32'({ptag_width'(rtag[1]), 2'b00}));
      if (translation_en_i)
        hit_cnt_o += int'(ev[0]) + int'(ev[1]);

      // walker request, instruction side first
      exp_req = (pend[0] | pend[1]) & ~wr_v;
      sel_d   = busy ? serve_d : ~pend[0];
      exp_tag = ptag_q[sel_d];
      check("fill_req_v_o", 32'(fill_req_v_i), 32'(exp_req));
      if (exp_req)
        check("fill_req_vtag_o", 32'(fill_req_vtag_i), 32'(exp_tag));

      for (int s = 0; s < 2; s++) begin
        req = (s == 0) ? ifetch_req_i : dmem_req_i;
        if (wr_v && int'(wr_d) == s)
          req = '{v: 1'b1, w: 1'b1, vtag: wr_tag};
        rd  = req.v & ~req.w;
        byp = rd & last_rd[s] & (req.vtag == rtag[s]);
        if (em[s] && !pend[s])
          ptag_q[s] = rtag[s];
        if (rd && !byp)
          rhit[s] = ref_lookup(s, req.vtag, rdat[s]);
        rv[s]      = rd;
        last_rd[s] = rd;
        rtag[s]    = req.vtag;
        if (flush_i) begin
          for (int i = 0; i < max_els; i++)
            vld[s][i] = 1'b0;
        end else if (req.v && req.w) begin
          ref_write(s, req.vtag, wr_pte);
        end
      end

      fill_hit = fill_v_i & exp_req;
      if (fill_hit)
        fill_cnt_o++;
      for (int s = 0; s < 2; s++) begin
        if (flush_i)
          pend[s] = 1'b0;
        else if (fill_hit && int'(sel_d) == s)
          pend[s] = 1'b0;
        else if (em[s])
          pend[s] = 1'b1;
      end
      busy    = flush_i ? 1'b0 : (exp_req & ~fill_v_i);
      serve_d = sel_d;
      wr_v    = fill_hit; // fill lands one cycle later
      if (fill_hit) begin
        wr_d   = sel_d;
        wr_tag = exp_tag;
        wr_pte = fill_pte_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: mmu_top.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_top (
  input  wire                                clk_i,
  input  wire                                reset_i,
  input  wire                                translation_en_i,
  input  wire                                flush_i,
  input  mmu_types_pkg::tlb_req_s            ifetch_req_i,
  input  mmu_types_pkg::tlb_req_s            dmem_req_i,
  input  wire                                fill_v_i,
  input  mmu_types_pkg::fill_pte_s           fill_pte_i,
  output logic                               i_v_o,
  output logic                               i_miss_v_o,
  output mmu_types_pkg::itlb_entry_s         i_entry_o,
  output logic                               d_v_o,
  output logic                               d_miss_v_o,
  output mmu_types_pkg::dtlb_entry_s         d_entry_o,
  output logic                               fill_req_v_o,
  output logic [mmu_cfg_pkg::vtag_width-1:0] fill_req_vtag_o
);
  import mmu_cfg_pkg::*;
  import mmu_types_pkg::*;

  tlb_req_s              i_req, d_req;
  itlb_entry_s           i_fill_entry;
  dtlb_entry_s           d_fill_entry;
  logic [vtag_width-1:0] i_vtag, d_vtag;

  tlb #(
    .els_p   (itlb_els),
    .entry_t (itlb_entry_s)
  ) itlb_u (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .flush_i          (flush_i),
    .translation_en_i (translation_en_i),
    .req_i            (i_req),
    .entry_i          (i_fill_entry),
    .v_o              (i_v_o),
    .miss_v_o         (i_miss_v_o),
    .vtag_o           (i_vtag),
    .entry_o          (i_entry_o)
  );

  tlb #(
    .els_p   (dtlb_els),
    .entry_t (dtlb_entry_s)
  ) dtlb_u (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .flush_i          (flush_i),
    .translation_en_i (translation_en_i),
    .req_i            (d_req),
    .entry_i          (d_fill_entry),
    .v_o              (d_v_o),
    .miss_v_o         (d_miss_v_o),
    .vtag_o           (d_vtag),
    .entry_o          (d_entry_o)
  );

  // one walker port shared by both sides
  tlb_miss_arbiter arb_u (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .flush_i         (flush_i),
    .i_miss_v_i      (i_miss_v_o),
    .d_miss_v_i      (d_miss_v_o),
    .i_vtag_i        (i_vtag),
    .d_vtag_i        (d_vtag),
    .ifetch_req_i    (ifetch_req_i),
    .dmem_req_i      (dmem_req_i),
    .fill_v_i        (fill_v_i),
    .fill_pte_i      (fill_pte_i),
    .i_req_o         (i_req),
    .d_req_o         (d_req),
    .i_fill_entry_o  (i_fill_entry),
    .d_fill_entry_o  (d_fill_entry),
    .fill_req_v_o    (fill_req_v_o),
    .fill_req_vtag_o (fill_req_vtag_o)
  );

endmodule

`default_nettype wire

// File: tlb_miss_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_miss_arbiter (
  input  wire                                clk_i,
  input  wire                                reset_i,
  input  wire                                flush_i,
  input  wire                                i_miss_v_i,
  input  wire                                d_miss_v_i,
  input  wire  [mmu_cfg_pkg::vtag_width-1:0] i_vtag_i,
  input  wire  [mmu_cfg_pkg::vtag_width-1:0] d_vtag_i,
  input  mmu_types_pkg::tlb_req_s            ifetch_req_i,
  input  mmu_types_pkg::tlb_req_s            dmem_req_i,
  input  wire                                fill_v_i,
  input  mmu_types_pkg::fill_pte_s           fill_pte_i,
  output mmu_types_pkg::tlb_req_s            i_req_o,
  output mmu_types_pkg::tlb_req_s            d_req_o,
  output mmu_types_pkg::itlb_entry_s         i_fill_entry_o,
  output mmu_types_pkg::dtlb_entry_s         d_fill_entry_o,
  output logic                               fill_req_v_o,
  output logic [mmu_cfg_pkg::vtag_width-1:0] fill_req_vtag_o
);
  import mmu_cfg_pkg::*;
  import mmu_types_pkg::*;

  logic                  i_pend_r, d_pend_r;
  logic [vtag_width-1:0] i_tag_r, d_tag_r;
  logic                  busy_r, serve_d_r, sel_d, fill_hit;
  logic                  fill_v_r, fill_d_r;
  logic [vtag_width-1:0] fill_vtag_r;
  fill_pte_s             fill_pte_r;

  // instruction side first, then stick with it until filled
  assign sel_d           = busy_r ? serve_d_r : ~i_pend_r;
  assign fill_req_v_o    = (i_pend_r | d_pend_r) & ~fill_v_r; // quiet in the write cycle
  assign fill_req_vtag_o = sel_d ? d_tag_r : i_tag_r;
  assign fill_hit        = fill_v_i & fill_req_v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      i_pend_r <= 1'b0;
      d_pend_r <= 1'b0;
      busy_r   <= 1'b0;
    end else begin
      if (fill_hit && !sel_d)
        i_pend_r <= 1'b0;
      else if (i_miss_v_i)
        i_pend_r <= 1'b1;
      if (fill_hit && sel_d)
        d_pend_r <= 1'b0;
      else if (d_miss_v_i)
        d_pend_r <= 1'b1;
      busy_r <= fill_req_v_o & ~fill_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      serve_d_r <= 1'b0;
      fill_v_r  <= 1'b0;
    end else begin
      serve_d_r <= sel_d;
      fill_v_r  <= fill_hit;
    end
  end

  // later misses on a pending side are dropped
  always_ff @(posedge clk_i) begin
    if (i_miss_v_i && !i_pend_r)
      i_tag_r <= i_vtag_i;
    if (d_miss_v_i && !d_pend_r)
      d_tag_r <= d_vtag_i;
    if (fill_hit) begin
      fill_d_r    <= sel_d;
      fill_vtag_r <= fill_req_vtag_o;
      fill_pte_r  <= fill_pte_i;
    end
  end

  assign i_fill_entry_o = '{ptag: fill_pte_r.ptag, x: fill_pte_r.x};
  assign d_fill_entry_o = '{ptag: fill_pte_r.ptag, r: fill_pte_r.r, w: fill_pte_r.w};

  always_comb begin
    i_req_o = ifetch_req_i;
    d_req_o = dmem_req_i;
    if (fill_v_r) begin
      if (fill_d_r)
        d_req_o = '{v: 1'b1, w: 1'b1, vtag: fill_vtag_r}; // write wins over lookup
      else
        i_req_o = '{v: 1'b1, w: 1'b1, vtag: fill_vtag_r};
    end
  end

endmodule

`default_nettype wire

// File: tlb.sv
`timescale 1ns/1ns
`default_nettype none

module tlb #(
  parameter int  els_p   = 8,
  parameter type entry_t = mmu_types_pkg::itlb_entry_s
) (
  input  wire                                clk_i,
  input  wire                                reset_i,
  input  wire                                flush_i,
  input  wire                                translation_en_i,
  input  mmu_types_pkg::tlb_req_s            req_i,
  input  entry_t                             entry_i,
  output logic                               v_o,
  output logic                               miss_v_o,
  output logic [mmu_cfg_pkg::vtag_width-1:0] vtag_o,
  output entry_t                             entry_o
);
  import mmu_cfg_pkg::*;

  logic                  read_v, write_v;
  logic                  r_v_r;
  logic [vtag_width-1:0] vtag_r;
  logic                  bypass, bypass_r;

  entry_t                cam_entry, passthrough_entry;
  logic                  cam_v, held_v_r, hit_v;

  assign read_v  = req_i.v & ~req_i.w;
  assign write_v = req_i.v & req_i.w;

  // same tag read back to back skips the CAM
  assign bypass = read_v & r_v_r & (req_i.vtag == vtag_r);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_v_r    <= 1'b0;
      bypass_r <= 1'b0;
    end else begin
      r_v_r    <= read_v;
      bypass_r <= bypass;
    end
  end

  always_ff @(posedge clk_i) begin
    vtag_r <= req_i.vtag;
  end

  tlb_cam #(
    .els_p   (els_p),
    .entry_t (entry_t)
  ) cam_u (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .w_v_i    (write_v),
    .w_nuke_i (flush_i),
    .w_tag_i  (req_i.vtag),
    .w_data_i (entry_i),
    .r_v_i    (read_v & ~bypass),
    .r_tag_i  (req_i.vtag),
    .r_data_o (cam_entry),
    .r_v_o    (cam_v)
  );

  // hit flag of the last real CAM read for the repeat case
  always_ff @(posedge clk_i) begin
    if (reset_i)
      held_v_r <= 1'b0;
    else if (!bypass_r)
      held_v_r <= cam_v;
  end

  assign hit_v = bypass_r ? held_v_r : cam_v;

  always_comb begin
    passthrough_entry      = '0; // no permissions
    passthrough_entry.ptag = {{ptag_pad_width{1'b0}}, vtag_r};
  end

  assign entry_o  = translation_en_i ? cam_entry : passthrough_entry; // cam data holds over a skipped read
  assign v_o      = translation_en_i ? (r_v_r & hit_v) : r_v_r;
  assign miss_v_o = r_v_r & ~v_o;
  assign vtag_o   = vtag_r;

endmodule

`default_nettype wire

// File: tlb_cam.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_cam #(
  parameter int  els_p   = 8,
  parameter type entry_t = mmu_types_pkg::itlb_entry_s
) (
  input  wire                               clk_i,
  input  wire                               reset_i,
  input  wire                               w_v_i,
  input  wire                               w_nuke_i,
  input  wire  [mmu_cfg_pkg::vtag_width-1:0] w_tag_i,
  input  entry_t                            w_data_i,
  input  wire                               r_v_i,
  input  wire  [mmu_cfg_pkg::vtag_width-1:0] r_tag_i,
  output entry_t                            r_data_o,
  output logic                              r_v_o
);
  import mmu_cfg_pkg::*;

  localparam int lg_els_lp = (els_p > 1) ? $clog2(els_p) : 1;

  logic   [els_p-1:0]      valid_r;
  logic   [vtag_width-1:0] tag_r [els_p];
  entry_t                  data_r [els_p];
  logic   [lg_els_lp-1:0]  victim_r;

  logic                    r_hit, w_hit;
  logic   [lg_els_lp-1:0]  r_idx, w_match_idx, w_idx;

  // fully associative match over the valid entries
  function automatic logic match(input logic [vtag_width-1:0] tag,
                                 output logic [lg_els_lp-1:0] idx);
    logic found;
    found = 1'b0;
    idx   = '0;
    for (int i = 0; i < els_p; i++) begin
      if (valid_r[i] && (tag_r[i] == tag)) begin
        found = 1'b1;
        idx   = lg_els_lp'(i);
      end
    end
    return found;
  endfunction

  always_comb begin
    r_hit = match(r_tag_i, r_idx);
    w_hit = match(w_tag_i, w_match_idx);
    w_idx = w_hit ? w_match_idx : victim_r; // update in place if present
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      victim_r <= '0;
    end else if (w_nuke_i) begin
      valid_r  <= '0;
    end else if (w_v_i) begin
      valid_r[w_idx] <= 1'b1;
      if (!w_hit)
        victim_r <= (victim_r == lg_els_lp'(els_p - 1)) ? '0 : victim_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_v_i && !w_nuke_i) begin
      tag_r[w_idx]  <= w_tag_i;
      data_r[w_idx] <= w_data_i;
    end
  end

  // registered read, data holds when idle
  always_ff @(posedge clk_i) begin
    if (reset_i)
      r_v_o <= 1'b0;
    else
      r_v_o <= r_v_i & r_hit;
  end

  always_ff @(posedge clk_i) begin
    if (r_v_i)
      r_data_o <= data_r[r_idx];
  end

endmodule

`default_nettype wire

// File: mmu_types_pkg.sv
`default_nettype none

package mmu_types_pkg;
  import mmu_cfg_pkg::*;

  // instruction side leaf, execute permission only
  typedef struct packed {
    logic [ptag_width-1:0] ptag;
    logic                  x;
  } itlb_entry_s;

  // data side leaf
  typedef struct packed {
    logic [ptag_width-1:0] ptag;
    logic                  r;
    logic                  w;
  } dtlb_entry_s;

  // leaf as returned by the page walker
  typedef struct packed {
    logic [ptag_width-1:0] ptag;
    logic                  r;
    logic                  w;
    logic                  x;
  } fill_pte_s;

  // one TLB access, w set means write of entry
  typedef struct packed {
    logic                  v;
    logic                  w;
    logic [vtag_width-1:0] vtag;
  } tlb_req_s;

endpackage

`default_nettype wire

// File: mmu_cfg_pkg.sv
`default_nettype none

// sizes shared by both TLBs and the miss arbiter
package mmu_cfg_pkg;

  // virtual page number bits looked up in the TLBs
  localparam int vtag_width = 20;

  // physical page number bits held in each entry
  localparam int ptag_width = 24;

  // entries per TLB
  localparam int itlb_els = 8;
  localparam int dtlb_els = 8;

  // passthrough pads the vtag up to the ptag width
  localparam int ptag_pad_width = ptag_width - vtag_width;

endpackage

`default_nettype wire
